// ==== gemm_cfg_pkg.sv ====
/*
 * GEMM engine configuration
 * Sizing parameters and the basic address, dimension and data types
 */
package gemm_cfg_pkg;

    // Edge length of the systolic array, also the tile size
    parameter int ARRAY_DIM = 4;

    parameter int ADDR_W = 12;
    parameter int DIM_W  = 8;
    parameter int ACC_W  = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DIM_W-1:0] dim_t;
    typedef logic signed [7:0] data_t;
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

// ==== gemm_isa_pkg.sv ====
/*
 * GEMM command set
 * Flag positions, controller and store encodings, output requantization
 */
package gemm_isa_pkg;

    parameter int FLAG_TRANSPOSE_B = 0;
    parameter int FLAG_REQUANT     = 1;

    typedef enum logic [3:0] {
        IDLE, SETUP, TILE_SETUP, LOAD_A, LOAD_B,
        CLEAR, STREAM, STORE, TILE_NEXT, DONE
    } ctrl_state_t;

    // How a finished tile is stored, chosen from the K tile index
    typedef enum logic [1:0] {
        DIRECT, ACC_INIT, ACC_ADD, ACC_FINAL
    } store_mode_t;

    // Holds a sum times an 8-bit scale without overflow
    typedef logic signed [gemm_cfg_pkg::ACC_W+8:0] wide_t;

    function automatic gemm_cfg_pkg::data_t saturate_i8(input wide_t v);
        if (v > 127)
            return 8'sh7f;
        if (v < -128)
            return 8'sh80;
        return gemm_cfg_pkg::data_t'(v[7:0]);
    endfunction

    // Scale, arithmetic shift with truncation, clamp
    function automatic gemm_cfg_pkg::data_t requantize(input gemm_cfg_pkg::acc_t sum,
                                                       input logic [7:0] scale,
                                                       input logic [7:0] shift);
        wide_t prod;
        prod = wide_t'(sum) * wide_t'({1'b0, scale});
        return saturate_i8(prod >>> shift);
    endfunction

endpackage

// ==== tile_if.sv ====
/*
 * Tile geometry from sequencer to result writer,
 * and operand buffer load writes from the sequencer
 */
interface tile_if #(parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM);
    localparam int EFF_W = $clog2(ARRAY_DIM + 1);

    logic                       store_start;
    logic                       store_done;
    logic [EFF_W-1:0]           m_eff;
    logic [EFF_W-1:0]           n_eff;
    gemm_cfg_pkg::addr_t        c_base;
    gemm_cfg_pkg::dim_t         row_stride;
    gemm_isa_pkg::store_mode_t  store_mode;
    logic                       requant;
    logic [7:0]                 scale;
    logic [7:0]                 shift;

    modport seq (output store_start, m_eff, n_eff, c_base, row_stride, store_mode,
                 requant, scale, shift, input store_done);
    modport writer (input store_start, m_eff, n_eff, c_base, row_stride, store_mode,
                    requant, scale, shift, output store_done);
endinterface

interface buf_load_if #(parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM);
    localparam int IDX_W = $clog2(ARRAY_DIM);

    logic                wr_en;
    logic                sel_b;
    logic [IDX_W-1:0]    row;
    logic [IDX_W-1:0]    col;
    gemm_cfg_pkg::data_t data;

    modport seq (output wr_en, sel_b, row, col, data);
    modport buffer (input wr_en, sel_b, row, col, data);
endinterface

// ==== gemm_tile_seq.sv ====
/*
 * GEMM tile sequencer
 * Walks M/N/K tiles, loads operands from SRAM and hands each tile to the writer
 */
module gemm_tile_seq #(
    parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM,
    localparam int EFF_W = $clog2(ARRAY_DIM + 1),
    localparam int IDX_W = $clog2(ARRAY_DIM),
    localparam int STEP_W = $clog2(3 * ARRAY_DIM)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    input  gemm_cfg_pkg::addr_t  cmd_src0,
    input  gemm_cfg_pkg::addr_t  cmd_src1,
    input  gemm_cfg_pkg::addr_t  cmd_dst,
    input  gemm_cfg_pkg::dim_t   cmd_m,
    input  gemm_cfg_pkg::dim_t   cmd_n,
    input  gemm_cfg_pkg::dim_t   cmd_k,
    input  logic [1:0]           cmd_flags,
    input  logic [7:0]           cmd_scale,
    input  logic [7:0]           cmd_shift,
    input  logic [7:0]           sram_rd_data,
    output logic                 sram_rd_en,
    output gemm_cfg_pkg::addr_t  sram_rd_addr,
    output logic                 busy,
    output logic                 done,
    output logic [EFF_W-1:0]     k_eff,
    output logic                 stream_en,
    output logic [STEP_W-1:0]    stream_cnt,
    output logic                 sa_clear,
    output logic                 sa_en,
    tile_if.seq                  ti,
    buf_load_if.seq              bl
);
    localparam gemm_cfg_pkg::dim_t AD = gemm_cfg_pkg::dim_t'(ARRAY_DIM);

    gemm_isa_pkg::ctrl_state_t state;
    gemm_cfg_pkg::addr_t r_src0, r_src1, r_dst, a_base, b_base, c_base;
    gemm_cfg_pkg::dim_t  r_m, r_n, r_k, m0, n0, k0, ld_stride;
    gemm_cfg_pkg::dim_t  m_tile, n_tile, k_tile, m_tiles, n_tiles, k_tiles;
    logic                r_trans, r_requant;
    logic [7:0]          r_scale, r_shift;
    logic [EFF_W-1:0]    m_eff, n_eff, rows_lim, cols_lim;
    logic [IDX_W-1:0]    load_row, load_col, ld_major, ld_minor;
    logic                load_phase, loading, last_row, last_col, stream_end;
    logic                last_m, last_n, last_k;
    gemm_cfg_pkg::addr_t ld_base;

    function automatic gemm_cfg_pkg::dim_t tiles_of(input gemm_cfg_pkg::dim_t d);
        return gemm_cfg_pkg::dim_t'((int'(d) + ARRAY_DIM - 1) / ARRAY_DIM);
    endfunction

    // Remaining extent from a tile start, clamped to the array edge
    function automatic logic [EFF_W-1:0] eff_of(input gemm_cfg_pkg::dim_t d,
                                                 input gemm_cfg_pkg::dim_t start);
        gemm_cfg_pkg::dim_t rem;
        rem = d - start;
        return (rem < AD) ? EFF_W'(rem) : EFF_W'(ARRAY_DIM);
    endfunction

    assign m0 = m_tile * AD;
    assign n0 = n_tile * AD;
    assign k0 = k_tile * AD;
    assign last_m = (m_tile == m_tiles - 1'b1);
    assign last_n = (n_tile == n_tiles - 1'b1);
    assign last_k = (k_tile == k_tiles - 1'b1);

    assign busy      = (state != gemm_isa_pkg::IDLE);
    assign done      = (state == gemm_isa_pkg::DONE);
    assign sa_clear  = (state == gemm_isa_pkg::CLEAR);
    assign stream_en = (state == gemm_isa_pkg::STREAM);
    assign sa_en     = stream_en;
    assign stream_end = (stream_cnt == STEP_W'(k_eff) + STEP_W'(m_eff) + STEP_W'(n_eff) - 1'b1);

    // ============================================================
    // Operand load walk, row-major, read then capture
    // ============================================================
    assign loading  = (state == gemm_isa_pkg::LOAD_A) || (state == gemm_isa_pkg::LOAD_B);
    assign rows_lim = (state == gemm_isa_pkg::LOAD_A) ? m_eff : k_eff;
    assign cols_lim = (state == gemm_isa_pkg::LOAD_A) ? k_eff : n_eff;
    assign last_row = (EFF_W'(load_row) == rows_lim - 1'b1);
    assign last_col = (EFF_W'(load_col) == cols_lim - 1'b1);

    always_comb begin
        ld_base   = a_base;
        ld_stride = r_k;
        ld_major  = load_row;
        ld_minor  = load_col;
        if (state == gemm_isa_pkg::LOAD_B) begin
            ld_base = b_base;
            // Transposed B sits in memory as N rows of K
            if (r_trans) begin
                ld_major = load_col;
                ld_minor = load_row;
            end else begin
                ld_stride = r_n;
            end
        end
    end

    assign sram_rd_en   = loading && !load_phase;
    assign sram_rd_addr = ld_base + ld_major * ld_stride + ld_minor;

    assign bl.wr_en = loading && load_phase;
    assign bl.sel_b = (state == gemm_isa_pkg::LOAD_B);
    assign bl.row   = load_row;
    assign bl.col   = load_col;
    assign bl.data  = gemm_cfg_pkg::data_t'(sram_rd_data);

    // Tile handoff to the writer
    assign ti.store_start = stream_en && stream_end;
    assign ti.m_eff       = m_eff;
    assign ti.n_eff       = n_eff;
    assign ti.c_base      = c_base;
    assign ti.row_stride  = r_n;
    assign ti.requant     = r_requant;
    assign ti.scale       = r_scale;
    assign ti.shift       = r_shift;
    assign ti.store_mode  = (k_tiles == 1) ? gemm_isa_pkg::DIRECT :
                            (k_tile == 0)  ? gemm_isa_pkg::ACC_INIT :
                            last_k         ? gemm_isa_pkg::ACC_FINAL : gemm_isa_pkg::ACC_ADD;

    // ============================================================
    // Controller
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= gemm_isa_pkg::IDLE;
            m_tile     <= '0;
            n_tile     <= '0;
            k_tile     <= '0;
            load_row   <= '0;
            load_col   <= '0;
            load_phase <= 1'b0;
            stream_cnt <= '0;
        end else begin
            case (state)
                gemm_isa_pkg::IDLE:
                    if (cmd_valid)
                        state <= gemm_isa_pkg::SETUP;
                gemm_isa_pkg::SETUP: begin
                    m_tile <= '0;
                    n_tile <= '0;
                    k_tile <= '0;
                    state  <= gemm_isa_pkg::TILE_SETUP;
                end
                gemm_isa_pkg::TILE_SETUP: begin
                    load_row   <= '0;
                    load_col   <= '0;
                    load_phase <= 1'b0;
                    state      <= gemm_isa_pkg::LOAD_A;
                end
                gemm_isa_pkg::LOAD_A, gemm_isa_pkg::LOAD_B: begin
                    load_phase <= !load_phase;
                    if (load_phase) begin
                        if (!last_col) begin
                            load_col <= load_col + 1'b1;
                        end else if (!last_row) begin
                            load_col <= '0;
                            load_row <= load_row + 1'b1;
                        end else begin
                            load_col <= '0;
                            load_row <= '0;
                            state    <= (state == gemm_isa_pkg::LOAD_A) ?
                                        gemm_isa_pkg::LOAD_B : gemm_isa_pkg::CLEAR;
                        end
                    end
                end
                gemm_isa_pkg::CLEAR: begin
                    stream_cnt <= '0;
                    state      <= gemm_isa_pkg::STREAM;
                end
                gemm_isa_pkg::STREAM: begin
                    stream_cnt <= stream_cnt + 1'b1;
                    if (stream_end)
                        state <= gemm_isa_pkg::STORE;
                end
                gemm_isa_pkg::STORE:
                    if (ti.store_done)
                        state <= gemm_isa_pkg::TILE_NEXT;
                gemm_isa_pkg::TILE_NEXT: begin
                    // K innermost, then N, then M
                    state <= gemm_isa_pkg::TILE_SETUP;
                    if (!last_k) begin
                        k_tile <= k_tile + 1'b1;
                    end else begin
                        k_tile <= '0;
                        if (!last_n) begin
                            n_tile <= n_tile + 1'b1;
                        end else begin
                            n_tile <= '0;
                            if (!last_m)
                                m_tile <= m_tile + 1'b1;
                            else
                                state <= gemm_isa_pkg::DONE;
                        end
                    end
                end
                default:
                    state <= gemm_isa_pkg::IDLE;
            endcase
        end
    end

    // Command fields and per-tile geometry
    always_ff @(posedge clk) begin
        if (state == gemm_isa_pkg::IDLE && cmd_valid) begin
            r_src0    <= cmd_src0;
            r_src1    <= cmd_src1;
            r_dst     <= cmd_dst;
            r_m       <= cmd_m;
            r_n       <= cmd_n;
            r_k       <= cmd_k;
            r_trans   <= cmd_flags[gemm_isa_pkg::FLAG_TRANSPOSE_B];
            r_requant <= cmd_flags[gemm_isa_pkg::FLAG_REQUANT];
            r_scale   <= cmd_scale;
            r_shift   <= cmd_shift;
        end
        if (state == gemm_isa_pkg::SETUP) begin
            m_tiles <= tiles_of(r_m);
            n_tiles <= tiles_of(r_n);
            k_tiles <= tiles_of(r_k);
        end
        if (state == gemm_isa_pkg::TILE_SETUP) begin
            m_eff  <= eff_of(r_m, m0);
            n_eff  <= eff_of(r_n, n0);
            k_eff  <= eff_of(r_k, k0);
            a_base <= r_src0 + m0 * r_k + k0;
            b_base <= r_trans ? r_src1 + n0 * r_k + k0 : r_src1 + k0 * r_n + n0;
            c_base <= r_dst + m0 * r_n + n0;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {[gemm_isa_pkg::IDLE : gemm_isa_pkg::DONE]});

endmodule

// ==== operand_buffer.sv ====
/*
 * Operand buffer
 * Holds the A and B tiles and presents them skewed to the systolic array
 */
module operand_buffer #(
    parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM,
    localparam int EFF_W = $clog2(ARRAY_DIM + 1),
    localparam int IDX_W = $clog2(ARRAY_DIM),
    localparam int STEP_W = $clog2(3 * ARRAY_DIM)
) (
    input  logic                clk,
    input  logic                rst_n,
    buf_load_if.buffer          bl,
    input  logic                stream_en,
    input  logic [STEP_W-1:0]   stream_cnt,
    input  logic [EFF_W-1:0]    k_eff,
    output gemm_cfg_pkg::data_t a_col [ARRAY_DIM],
    output gemm_cfg_pkg::data_t b_row [ARRAY_DIM]
);
    // A indexed [m][k], B indexed [k][n]
    gemm_cfg_pkg::data_t buf_a [ARRAY_DIM][ARRAY_DIM];
    gemm_cfg_pkg::data_t buf_b [ARRAY_DIM][ARRAY_DIM];

    always_ff @(posedge clk) begin
        if (bl.wr_en && !bl.sel_b)
            buf_a[bl.row][bl.col] <= bl.data;
        if (bl.wr_en && bl.sel_b)
            buf_b[bl.row][bl.col] <= bl.data;
    end

    // ============================================================
    // Skewed streaming
    // ============================================================
    // Row i of A and column i of B both lag the step count by i
    always_comb begin
        int t;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            t = int'(stream_cnt) - i;
            a_col[i] = '0;
            b_row[i] = '0;
            if (stream_en && t >= 0 && t < int'(k_eff)) begin
                a_col[i] = buf_a[i][t[IDX_W-1:0]];
                b_row[i] = buf_b[t[IDX_W-1:0]][i];
            end
        end
    end

    // Operand bytes from SRAM must be known when captured
    a_load_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        bl.wr_en |-> !$isunknown(bl.data));

endmodule

// ==== systolic_array.sv ====
/*
 * Output-stationary systolic array of int8 MACs
 * A moves right and B moves down through registers, sums stay in place
 */
module systolic_array #(
    parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                en,
    input  gemm_cfg_pkg::data_t a_col [ARRAY_DIM],
    input  gemm_cfg_pkg::data_t b_row [ARRAY_DIM],
    output gemm_cfg_pkg::acc_t  sums  [ARRAY_DIM][ARRAY_DIM]
);
    gemm_cfg_pkg::data_t a_fwd [ARRAY_DIM][ARRAY_DIM];
    gemm_cfg_pkg::data_t b_fwd [ARRAY_DIM][ARRAY_DIM];
    gemm_cfg_pkg::data_t a_in  [ARRAY_DIM][ARRAY_DIM];
    gemm_cfg_pkg::data_t b_in  [ARRAY_DIM][ARRAY_DIM];

    // Edge cells take the streamed operands, inner cells the neighbour's register
    // (modulo index only keeps the unused branch in range)
    always_comb begin
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                a_in[i][j] = (j == 0) ? a_col[i] : a_fwd[i][(j + ARRAY_DIM - 1) % ARRAY_DIM];
                b_in[i][j] = (i == 0) ? b_row[j] : b_fwd[(i + ARRAY_DIM - 1) % ARRAY_DIM][j];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || clear) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                for (int j = 0; j < ARRAY_DIM; j++) begin
                    sums[i][j]  <= '0;
                    a_fwd[i][j] <= '0;
                    b_fwd[i][j] <= '0;
                end
            end
        end else if (en) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                for (int j = 0; j < ARRAY_DIM; j++) begin
                    sums[i][j]  <= sums[i][j] + gemm_cfg_pkg::acc_t'(a_in[i][j] * b_in[i][j]);
                    a_fwd[i][j] <= a_in[i][j];
                    b_fwd[i][j] <= b_in[i][j];
                end
            end
        end
    end

endmodule

// ==== result_writer.sv ====
/*
 * Result writer
 * Walks a finished tile, accumulates K tiles in scratch and writes int8 to SRAM
 */
module result_writer #(
    parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM,
    localparam int EFF_W = $clog2(ARRAY_DIM + 1),
    localparam int IDX_W = $clog2(ARRAY_DIM),
    localparam int SCR_W = $clog2(ARRAY_DIM * ARRAY_DIM)
) (
    input  logic                clk,
    input  logic                rst_n,
    tile_if.writer              ti,
    input  gemm_cfg_pkg::acc_t  sums [ARRAY_DIM][ARRAY_DIM],
    output logic                sram_wr_en,
    output gemm_cfg_pkg::addr_t sram_wr_addr,
    output logic [7:0]          sram_wr_data
);
    // Partial sums carried across K tiles
    gemm_cfg_pkg::acc_t scratch [ARRAY_DIM*ARRAY_DIM];
    gemm_cfg_pkg::acc_t scr_q, total;

    logic             active, phase, two_step, elem_done, last_elem, scr_we;
    logic [IDX_W-1:0] row, col;
    logic [SCR_W-1:0] scr_idx;

    // ADD and FINAL read scratch first, then write in the second cycle
    assign two_step  = ti.store_mode inside {gemm_isa_pkg::ACC_ADD, gemm_isa_pkg::ACC_FINAL};
    assign elem_done = active && (!two_step || phase);
    assign last_elem = elem_done && (EFF_W'(row) == ti.m_eff - 1'b1)
                                 && (EFF_W'(col) == ti.n_eff - 1'b1);
    assign ti.store_done = last_elem;

    assign scr_idx = SCR_W'(int'(row) * ARRAY_DIM + int'(col));
    assign total   = two_step ? scr_q + sums[row][col] : sums[row][col];
    assign scr_we  = active && (ti.store_mode == gemm_isa_pkg::ACC_INIT ||
                                (ti.store_mode == gemm_isa_pkg::ACC_ADD && phase));

    // ============================================================
    // Store walk, row by row
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            phase  <= 1'b0;
            row    <= '0;
            col    <= '0;
        end else if (ti.store_start) begin
            active <= 1'b1;
            phase  <= 1'b0;
            row    <= '0;
            col    <= '0;
        end else if (active) begin
            phase <= two_step && !phase;
            if (last_elem) begin
                active <= 1'b0;
            end else if (elem_done) begin
                if (EFF_W'(col) == ti.n_eff - 1'b1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && !phase)
            scr_q <= scratch[scr_idx];
        if (scr_we)
            scratch[scr_idx] <= total;
    end

    assign sram_wr_en   = active && (ti.store_mode == gemm_isa_pkg::DIRECT ||
                                     (ti.store_mode == gemm_isa_pkg::ACC_FINAL && phase));
    assign sram_wr_addr = ti.c_base + row * ti.row_stride + col;
    assign sram_wr_data = ti.requant ? gemm_isa_pkg::requantize(total, ti.scale, ti.shift)
                                     : gemm_isa_pkg::saturate_i8(total);

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        sram_wr_en |-> !$isunknown(sram_wr_addr));

endmodule

// ==== gemm_core.sv ====
/*
 * Tiled INT8 GEMM engine top level
 */
module gemm_core #(
    parameter int ARRAY_DIM = gemm_cfg_pkg::ARRAY_DIM,
    localparam int EFF_W = $clog2(ARRAY_DIM + 1),
    localparam int STEP_W = $clog2(3 * ARRAY_DIM)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  gemm_cfg_pkg::addr_t cmd_src0,
    input  gemm_cfg_pkg::addr_t cmd_src1,
    input  gemm_cfg_pkg::addr_t cmd_dst,
    input  gemm_cfg_pkg::dim_t  cmd_m,
    input  gemm_cfg_pkg::dim_t  cmd_n,
    input  gemm_cfg_pkg::dim_t  cmd_k,
    input  logic [1:0]          cmd_flags,
    input  logic [7:0]          cmd_scale,
    input  logic [7:0]          cmd_shift,
    output logic                sram_rd_en,
    output gemm_cfg_pkg::addr_t sram_rd_addr,
    input  logic [7:0]          sram_rd_data,
    output logic                sram_wr_en,
    output gemm_cfg_pkg::addr_t sram_wr_addr,
    output logic [7:0]          sram_wr_data,
    output logic                busy,
    output logic                done
);
    tile_if     #(.ARRAY_DIM(ARRAY_DIM)) tile_bus ();
    buf_load_if #(.ARRAY_DIM(ARRAY_DIM)) load_bus ();

    logic [EFF_W-1:0]    k_eff;
    logic [STEP_W-1:0]   stream_cnt;
    logic                stream_en, sa_clear, sa_en;
    gemm_cfg_pkg::data_t a_col [ARRAY_DIM];
    gemm_cfg_pkg::data_t b_row [ARRAY_DIM];
    gemm_cfg_pkg::acc_t  sums  [ARRAY_DIM][ARRAY_DIM];

    gemm_tile_seq #(.ARRAY_DIM(ARRAY_DIM)) u_seq (
        .clk, .rst_n, .cmd_valid, .cmd_src0, .cmd_src1, .cmd_dst,
        .cmd_m, .cmd_n, .cmd_k, .cmd_flags, .cmd_scale, .cmd_shift,
        .sram_rd_data, .sram_rd_en, .sram_rd_addr, .busy, .done,
        .k_eff, .stream_en, .stream_cnt, .sa_clear, .sa_en,
        .ti(tile_bus.seq), .bl(load_bus.seq)
    );

    operand_buffer #(.ARRAY_DIM(ARRAY_DIM)) u_buf (
        .clk, .rst_n, .bl(load_bus.buffer), .stream_en, .stream_cnt, .k_eff,
        .a_col, .b_row
    );

    systolic_array #(.ARRAY_DIM(ARRAY_DIM)) u_array (
        .clk, .rst_n, .clear(sa_clear), .en(sa_en), .a_col, .b_row, .sums
    );

    result_writer #(.ARRAY_DIM(ARRAY_DIM)) u_writer (
        .clk, .rst_n, .ti(tile_bus.writer), .sums,
        .sram_wr_en, .sram_wr_addr, .sram_wr_data
    );

endmodule

// ==== tb_gemm.sv ====
/*
 * Testbench for the tiled INT8 GEMM engine
 * Byte SRAM model, commands and expected bytes from a stimulus file,
 * status and write range checks
 */
module tb_gemm;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD = 100;
    localparam int    MEM_BYTES  = 4096;
    // Longest command takes under 300 cycles and the whole run under 1000
    localparam int    MAX_CYCLES = 20000;
    localparam string STIM_FILE  = "gemm_stim.txt";

    logic                clk;
    logic                rst_n;
    logic                cmd_valid;
    gemm_cfg_pkg::addr_t cmd_src0;
    gemm_cfg_pkg::addr_t cmd_src1;
    gemm_cfg_pkg::addr_t cmd_dst;
    gemm_cfg_pkg::dim_t  cmd_m;
    gemm_cfg_pkg::dim_t  cmd_n;
    gemm_cfg_pkg::dim_t  cmd_k;
    logic [1:0]          cmd_flags;
    logic [7:0]          cmd_scale;
    logic [7:0]          cmd_shift;
    logic                sram_rd_en;
    gemm_cfg_pkg::addr_t sram_rd_addr;
    logic [7:0]          sram_rd_data;
    logic                sram_wr_en;
    gemm_cfg_pkg::addr_t sram_wr_addr;
    logic [7:0]          sram_wr_data;
    logic                busy;
    logic                done;

    // SRAM model storage and preload port
    logic [7:0]          mem [MEM_BYTES];
    logic [7:0]          rd_q;
    logic                pre_en;
    gemm_cfg_pkg::addr_t pre_addr;
    logic [7:0]          pre_data;

    // Current command region, watched by the write monitor
    int    cur_dst;
    int    cur_m;
    int    cur_n;
    int    wr_count;
    int    range_errors;
    int    data_errors;
    int    status_errors;
    int    cycles;
    string test_name;

    gemm_core u_gemm_core (
        .clk, .rst_n, .cmd_valid, .cmd_src0, .cmd_src1, .cmd_dst,
        .cmd_m, .cmd_n, .cmd_k, .cmd_flags, .cmd_scale, .cmd_shift,
        .sram_rd_en, .sram_rd_addr, .sram_rd_data,
        .sram_wr_en, .sram_wr_addr, .sram_wr_data,
        .busy, .done
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // SRAM model, one cycle read latency
    // ============================================================
    initial begin
        for (int a = 0; a < MEM_BYTES; a++)
            mem[a] = 8'(a ^ (a >> 4) ^ (a >> 8));
        rd_q = '0;
        forever begin
            @(posedge clk);
            if (sram_rd_en)
                rd_q <= mem[sram_rd_addr];
            if (sram_wr_en)
                mem[sram_wr_addr] <= sram_wr_data;
            if (pre_en)
                mem[pre_addr] <= pre_data;
        end
    end

    // Read data reaches the DUT on the falling edge
    initial begin
        sram_rd_data = '0;
        forever begin
            @(negedge clk);
            sram_rd_data = rd_q;
        end
    end

    // Every write must land inside the C matrix of the running command
    initial begin
        wr_count = 0;
        range_errors = 0;
        forever begin
            @(negedge clk);
            if (sram_wr_en) begin
                wr_count++;
                if (int'(sram_wr_addr) < cur_dst ||
                    int'(sram_wr_addr) >= cur_dst + cur_m * cur_n) begin
                    range_errors++;
                    $display("%s: write outside the C matrix at address %03h",
                             test_name, sram_wr_addr);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic write_preload(input int addr, input int val);
        pre_en   = 1'b1;
        pre_addr = gemm_cfg_pkg::addr_t'(addr);
        pre_data = 8'(val);
        @(negedge clk);
    endtask

    task automatic check_byte(input int addr, input int val);
        if (mem[addr] !== 8'(val)) begin
            data_errors++;
            $display("ERR %s addr %03h expected %02h actual %02h",
                     test_name, addr[11:0], val[7:0], mem[addr]);
        end
    endtask

    // ============================================================
    // One command with busy and done checks
    // ============================================================
    task automatic run_command(input int src0, src1, dst, m, n, k, flags, scale, shift);
        int wr_start;
        cur_dst  = dst;
        cur_m    = m;
        cur_n    = n;
        wr_start = wr_count;
        if (busy) begin
            status_errors++;
            $display("%s: busy already high before the command", test_name);
        end
        cmd_src0  = gemm_cfg_pkg::addr_t'(src0);
        cmd_src1  = gemm_cfg_pkg::addr_t'(src1);
        cmd_dst   = gemm_cfg_pkg::addr_t'(dst);
        cmd_m     = gemm_cfg_pkg::dim_t'(m);
        cmd_n     = gemm_cfg_pkg::dim_t'(n);
        cmd_k     = gemm_cfg_pkg::dim_t'(k);
        cmd_flags = 2'(flags);
        cmd_scale = 8'(scale);
        cmd_shift = 8'(shift);
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        if (!busy) begin
            status_errors++;
            $display("%s: busy did not rise the cycle after cmd_valid", test_name);
        end
        // A second command while busy points elsewhere and must be ignored
        @(negedge clk);
        cmd_dst   = 12'h800;
        cmd_m     = 8'd1;
        cmd_n     = 8'd1;
        cmd_k     = 8'd1;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        while (busy && !done)
            @(negedge clk);
        if (!done) begin
            status_errors++;
            $display("%s: busy fell without a done pulse", test_name);
        end else begin
            @(negedge clk);
            if (done || busy) begin
                status_errors++;
                $display("%s: done lasted more than one cycle or busy stayed high",
                         test_name);
            end
            repeat (3) @(negedge clk);
            if (busy) begin
                status_errors++;
                $display("%s: the command given while busy was started", test_name);
            end
        end
        if (wr_count - wr_start != m * n) begin
            data_errors++;
            $display("ERR %s write count expected %0d actual %0d",
                     test_name, m * n, wr_count - wr_start);
        end
    endtask

    // ============================================================
    // Stimulus file reader
    // ============================================================
    initial begin
        int    fd;
        int    rc;
        int    addr;
        int    cnt;
        int    val;
        int    src0, src1, dst, m, n, k, flags, scale, shift;
        string tok;
        string line;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_src0      = '0;
        cmd_src1      = '0;
        cmd_dst       = '0;
        cmd_m         = '0;
        cmd_n         = '0;
        cmd_k         = '0;
        cmd_flags     = '0;
        cmd_scale     = '0;
        cmd_shift     = '0;
        pre_en        = 1'b0;
        pre_addr      = '0;
        pre_data      = '0;
        cur_dst       = 0;
        cur_m         = 0;
        cur_n         = 0;
        data_errors   = 0;
        status_errors = 0;
        test_name     = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        if (busy || done || sram_rd_en || sram_wr_en) begin
            status_errors++;
            $display("Outputs not low after reset");
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            status_errors++;
            $display("Cannot open the stimulus file %s", STIM_FILE);
        end else begin
            rc = $fscanf(fd, "%s", tok);
            while (rc == 1) begin
                if (tok == "#") begin
                    rc = $fgets(line, fd);
                end else if (tok == "P") begin
                    rc = $fscanf(fd, "%h %d", addr, cnt);
                    for (int i = 0; i < cnt; i++) begin
                        rc = $fscanf(fd, "%h", val);
                        write_preload(addr + i, val);
                    end
                    pre_en = 1'b0;
                end else if (tok == "C") begin
                    rc = $fscanf(fd, "%s %h %h %h %d %d %d %d %d %d", test_name,
                                 src0, src1, dst, m, n, k, flags, scale, shift);
                    run_command(src0, src1, dst, m, n, k, flags, scale, shift);
                end else if (tok == "E") begin
                    rc = $fscanf(fd, "%h %d", addr, cnt);
                    for (int i = 0; i < cnt; i++) begin
                        rc = $fscanf(fd, "%h", val);
                        check_byte(addr + i, val);
                    end
                end else begin
                    status_errors++;
                    $display("Unknown record %s in the stimulus file", tok);
                end
                rc = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        $display("Data errors %0d, status errors %0d, write range errors %0d",
                 data_errors, status_errors, range_errors);
        if (data_errors + status_errors + range_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== gemm_stim.txt ====
# P <addr hex> <count> <bytes hex> preloads SRAM bytes
# C <name> <src0> <src1> <dst> hex then <m> <n> <k> <flags> <scale> <shift> decimal
# E <addr hex> <count> <bytes hex> are the expected bytes after the last command
P 000 9 0a 14 1e ce d8 03 01 fe 01
P 010 9 02 01 00 03 ff 01 04 00 fe
P 020 9 02 03 04 01 ff 00 00 01 fe
C saturate_3x3x3 000 010 100 3 3 3 0 1 0
E 100 9 7f f6 d8 80 f6 d2 00 03 fc
C requant_3x3x3 000 010 110 3 3 3 2 3 4
E 110 9 25 fe f8 d9 fe f7 00 00 ff
C transpose_b 000 020 120 3 3 3 1 1 0
E 120 9 7f f6 d8 80 f6 d2 00 03 fc
P 040 24 00 01 02 03 01 02 03 04 02 03 04 05 03 04 05 06 04 05 06 07 05 06 07 08
P 060 20 00 ff fe fd fc 01 00 ff fe fd 02 01 00 ff fe 03 02 01 00 ff
C tiled_6x5x4 040 060 200 6 5 4 0 1 0
E 200 15 0e 08 02 fc f6 14 0a 00 f6 ec 1a 0c fe f0 e2
E 20f 15 20 0e fc ea d8 26 10 fa e4 ce 2c 12 f8 de c4
P 080 15 01 02 03 04 05 06 07 08 09 0a ff fe fd fc fb
P 08f 15 fa f9 f8 f7 f6 fe fc fa f8 f6 f4 f2 f0 ee ec
P 0a0 15 00 01 02 01 02 03 02 03 04 03 04 05 04 05 06
P 0af 15 05 06 07 06 07 08 07 08 09 08 09 0a 09 0a 0b
C ktiles_3x3x10 080 0a0 300 3 3 10 2 5 5
E 300 9 33 3c 44 cc c3 bb 98 87 80

// ==== gemm_core.f ====
gemm_cfg_pkg.sv
gemm_isa_pkg.sv
tile_if.sv
gemm_tile_seq.sv
operand_buffer.sv
systolic_array.sv
result_writer.sv
gemm_core.sv
tb_gemm.sv

// ==== Makefile ====
# Verilator build and run for the GEMM engine testbench

VERILATOR ?= verilator
TOP       ?= tb_gemm
FLIST     ?= gemm_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= NO ERRORS

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
